//--- logic/scpad_macros.svh
`ifndef SCPAD_MACROS_SVH
`define SCPAD_MACROS_SVH

// scratchpad row geometry
`define SCPAD_LANES      32
`define LANE_WIDTH       16

// dram beat geometry
`define BEAT_LANES       4
`define MAX_BEATS        8

// address widths
`define DRAM_ADDR_WIDTH  32
`define SRAM_ROW_WIDTH   6

`endif

//--- logic/scpad_pkg.sv
`include "scpad_macros.svh"

package scpad_pkg;

    // basic vectors
    typedef logic [`LANE_WIDTH-1:0]                 lane_t;
    typedef logic [`BEAT_LANES*`LANE_WIDTH-1:0]     beat_data_t;
    typedef logic [`DRAM_ADDR_WIDTH-1:0]            dram_addr_t;
    typedef logic [`SCPAD_LANES-1:0]                vec_mask_t;
    typedef logic [`SRAM_ROW_WIDTH-1:0]             sram_row_t;

    // index runs 0..7, count runs 1..8 so it needs one more bit
    typedef logic [$clog2(`MAX_BEATS)-1:0]          beat_idx_t;
    typedef logic [$clog2(`MAX_BEATS):0]            beat_count_t;

    // lane 0 sits in the lowest bits of the row
    typedef lane_t [`SCPAD_LANES-1:0]               row_data_t;

    // writeback command
    typedef struct packed {
        sram_row_t   row;
        dram_addr_t  dram_addr;
        vec_mask_t   vector_mask;
        beat_count_t num_beats;
    } wb_cmd_t;

    // one 64-bit dram write beat
    typedef struct packed {
        logic        valid;
        beat_data_t  wdata;
        dram_addr_t  dram_addr;
        vec_mask_t   vector_mask;
    } dram_write_req_t;

    // writeback sequencer states
    typedef enum logic [2:0] {
        IDLE,
        READ,
        WAIT_DATA,
        EMIT,
        DONE
    } wb_state_t;

endpackage

//--- logic/wb_beat_counter.sv
`timescale 1ns/1ps

module wb_beat_counter
    import scpad_pkg::*;
(
    input  logic        clk,
    input  logic        n_rst,
    input  logic        advance,
    input  logic        clear,
    input  beat_count_t num_beats,
    output beat_idx_t   beat_idx,
    output logic        last_beat
);

    // beats already loaded into the packer
    beat_count_t count;
    beat_count_t count_inc;

    assign count_inc = count + beat_count_t'(1);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (advance) begin
            count <= count_inc;
        end
    end

    // high while the beat about to load brings the count to num_beats
    assign last_beat = (count_inc == num_beats);

    // low bits select the lane group
    assign beat_idx = count[$bits(beat_idx_t)-1:0];

endmodule

//--- logic/wb_row_buffer.sv
`timescale 1ns/1ps

module wb_row_buffer
    import scpad_pkg::*;
(
    input  logic      clk,
    input  logic      n_rst,
    input  logic      capture,
    input  row_data_t sram_rddata,
    output row_data_t row
);

    // full 512-bit row, frees the sram after a single read
    row_data_t row_q;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            row_q <= '0;
        end else if (capture) begin
            // read data is valid in the capture cycle
            row_q <= sram_rddata;
        end
    end

    assign row = row_q;

endmodule

//--- logic/wb_beat_packer.sv
`timescale 1ns/1ps

`include "scpad_macros.svh"

module wb_beat_packer
    import scpad_pkg::*;
(
    input  logic            clk,
    input  logic            n_rst,
    input  logic            load,
    input  logic            clear,
    input  beat_idx_t       beat_idx,
    input  row_data_t       row,
    input  dram_addr_t      dram_addr_base,
    input  vec_mask_t       vector_mask,
    output dram_write_req_t dram_write_req
);

    dram_write_req_t req_q;
    dram_write_req_t req_next;

    // first lane of the selected group
    logic [$clog2(`SCPAD_LANES)-1:0] lane_base;

    assign lane_base = beat_idx * `BEAT_LANES;

    always_comb begin
        req_next.valid = 1'b1;

        // highest lane of the group lands in the top bits
        req_next.wdata = row[lane_base +: `BEAT_LANES];

        // base above bit 4, beat index in bits 4..2, low two bits zero
        req_next.dram_addr = {
            dram_addr_base[`DRAM_ADDR_WIDTH-1:5],
            beat_idx,
            2'b00
        };

        // mask is forwarded as is
        req_next.vector_mask = vector_mask;
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            req_q <= '0;
        end else if (clear) begin
            req_q <= '0;
        end else if (load) begin
            req_q <= req_next;
        end
        // otherwise hold, keeps the beat steady under stall
    end

    assign dram_write_req = req_q;

endmodule

//--- logic/wb_ctrl_fsm.sv
`timescale 1ns/1ps

module wb_ctrl_fsm
    import scpad_pkg::*;
(
    input  logic        clk,
    input  logic        n_rst,
    input  logic        cmd_valid,
    input  wb_cmd_t     cmd,
    input  logic        dram_be_stall,
    input  logic        last_beat,
    output logic        sram_rd_en,
    output sram_row_t   sram_rd_row,
    output logic        row_capture,
    output logic        beat_load,
    output logic        beat_clear,
    output dram_addr_t  dram_addr_base,
    output vec_mask_t   vector_mask,
    output beat_count_t num_beats,
    output logic        busy,
    output logic        done
);

    wb_state_t state;
    wb_state_t next_state;
    wb_cmd_t   cmd_q;
    logic      rd_pulse;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state    <= IDLE;
            rd_pulse <= 1'b0;
        end else begin
            state    <= next_state;
            // second READ cycle carries the sram read
            rd_pulse <= (state == READ) && !rd_pulse;
        end
    end

    // command taken only when idle
    always_ff @(posedge clk) begin
        if (state == IDLE && cmd_valid) begin
            cmd_q <= cmd;
        end
    end

    always_comb begin
        next_state  = state;
        row_capture = 1'b0;
        beat_load   = 1'b0;
        beat_clear  = 1'b0;
        done        = 1'b0;

        case (state)
            IDLE: begin
                if (cmd_valid) begin
                    next_state = READ;
                end
            end
            READ: begin
                if (rd_pulse) begin
                    next_state = WAIT_DATA;
                end
            end
            WAIT_DATA: begin
                // sram data present this cycle
                row_capture = 1'b1;
                next_state  = EMIT;
            end
            EMIT: begin
                if (!dram_be_stall) begin
                    beat_load = 1'b1;
                    if (last_beat) begin
                        next_state = DONE;
                    end
                end
            end
            DONE: begin
                // last beat transfers here unless stalled
                if (!dram_be_stall) begin
                    done       = 1'b1;
                    beat_clear = 1'b1;
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    assign sram_rd_en     = rd_pulse;
    assign sram_rd_row    = cmd_q.row;
    assign dram_addr_base = cmd_q.dram_addr;
    assign vector_mask    = cmd_q.vector_mask;
    assign num_beats      = cmd_q.num_beats;
    assign busy           = (state != IDLE);

endmodule

//--- logic/dram_writeback_top.sv
`timescale 1ns/1ps

module dram_writeback_top
    import scpad_pkg::*;
(
    input  logic            clk,
    input  logic            n_rst,
    input  logic            cmd_valid,
    input  wb_cmd_t         cmd,
    output logic            sram_rd_en,
    output sram_row_t       sram_rd_row,
    input  row_data_t       sram_rddata,
    output dram_write_req_t dram_write_req,
    input  logic            dram_be_stall,
    output logic            busy,
    output logic            done
);

    // sequencer to datapath
    logic        row_capture;
    logic        beat_load;
    logic        beat_clear;
    logic        last_beat;
    dram_addr_t  dram_addr_base;
    vec_mask_t   vector_mask;
    beat_count_t num_beats;
    beat_idx_t   beat_idx;
    row_data_t   row;

    wb_ctrl_fsm wb_ctrl_fsm_inst (
        .clk            (clk),
        .n_rst          (n_rst),
        .cmd_valid      (cmd_valid),
        .cmd            (cmd),
        .dram_be_stall  (dram_be_stall),
        .last_beat      (last_beat),
        .sram_rd_en     (sram_rd_en),
        .sram_rd_row    (sram_rd_row),
        .row_capture    (row_capture),
        .beat_load      (beat_load),
        .beat_clear     (beat_clear),
        .dram_addr_base (dram_addr_base),
        .vector_mask    (vector_mask),
        .num_beats      (num_beats),
        .busy           (busy),
        .done           (done)
    );

    wb_beat_counter wb_beat_counter_inst (
        .clk       (clk),
        .n_rst     (n_rst),
        .advance   (beat_load),
        .clear     (beat_clear),
        .num_beats (num_beats),
        .beat_idx  (beat_idx),
        .last_beat (last_beat)
    );

    wb_row_buffer wb_row_buffer_inst (
        .clk         (clk),
        .n_rst       (n_rst),
        .capture     (row_capture),
        .sram_rddata (sram_rddata),
        .row         (row)
    );

    wb_beat_packer wb_beat_packer_inst (
        .clk            (clk),
        .n_rst          (n_rst),
        .load           (beat_load),
        .clear          (beat_clear),
        .beat_idx       (beat_idx),
        .row            (row),
        .dram_addr_base (dram_addr_base),
        .vector_mask    (vector_mask),
        .dram_write_req (dram_write_req)
    );

endmodule

//--- verif/dram_writeback_tb.sv
`timescale 1ns/1ps

`include "scpad_macros.svh"

module dram_writeback_tb
    import scpad_pkg::*;
;

    localparam int HALF_PERIOD   = 2;
    localparam int RESET_CYCLES  = 10;
    localparam int NUM_ENTRIES   = 8;
    localparam int ENTRY_CYCLES  = 40;
    localparam logic [15:0] LFSR_SEED = 16'd98;

    typedef logic [255:0] check_t;

    // one command plus how the testbench treats it
    typedef struct packed {
        wb_cmd_t cmd;
        logic    stall_on;
        logic    strobe_busy;
    } entry_t;

    logic            clk = 1'b0;
    logic            n_rst;
    logic            cmd_valid;
    wb_cmd_t         cmd;
    logic            sram_rd_en;
    sram_row_t       sram_rd_row;
    row_data_t       sram_rddata = '0;
    dram_write_req_t dram_write_req;
    logic            dram_be_stall;
    logic            busy;
    logic            done;

    entry_t          table_q [NUM_ENTRIES];
    string           names [NUM_ENTRIES];
    logic [15:0]     lfsr_q;

    // sram model state
    logic            rd_seen = 1'b0;
    sram_row_t       rd_row_seen = '0;

    always #(HALF_PERIOD) clk = ~clk;

    dram_writeback_top dram_writeback_top_inst (
        .clk            (clk),
        .n_rst          (n_rst),
        .cmd_valid      (cmd_valid),
        .cmd            (cmd),
        .sram_rd_en     (sram_rd_en),
        .sram_rd_row    (sram_rd_row),
        .sram_rddata    (sram_rddata),
        .dram_write_req (dram_write_req),
        .dram_be_stall  (dram_be_stall),
        .busy           (busy),
        .done           (done)
    );

    // lane j of row r holds r*256 + j
    function automatic lane_t model_lane(input sram_row_t r, input int j);
        int v;
        v = int'(r) * 256 + j;
        return lane_t'(v);
    endfunction

    function automatic row_data_t model_row(input sram_row_t r);
        row_data_t img;
        int j;
        for (j = 0; j < `SCPAD_LANES; j++) begin
            img[j] = model_lane(r, j);
        end
        return img;
    endfunction

    // lane 4k in the low bits, lane 4k+3 on top
    function automatic beat_data_t expect_wdata(input sram_row_t r, input int k);
        beat_data_t d;
        int i;
        for (i = 0; i < `BEAT_LANES; i++) begin
            d[i*`LANE_WIDTH +: `LANE_WIDTH] = model_lane(r, `BEAT_LANES * k + i);
        end
        return d;
    endfunction

    function automatic dram_addr_t expect_addr(input dram_addr_t base, input int k);
        dram_addr_t a;
        a = base;
        a[4:2] = 3'(k);
        a[1:0] = 2'b00;
        return a;
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic draw_stall(input logic enable, output logic stall);
        if (enable) begin
            stall = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end else begin
            stall = 1'b0;
        end
    endtask

    task automatic check_value(input string test, input string what,
                               input check_t expected, input check_t actual);
        assert (expected === actual) else begin
            $display("error: test %s, %s expected %0h actual %0h",
                     test, what, expected, actual);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic set_entry(input int idx, input string name, input sram_row_t row,
                             input dram_addr_t base, input vec_mask_t mask,
                             input int beats, input logic stall_on, input logic strobe);
        names[idx] = name;
        table_q[idx].cmd.row = row;
        table_q[idx].cmd.dram_addr = base;
        table_q[idx].cmd.vector_mask = mask;
        table_q[idx].cmd.num_beats = beat_count_t'(beats);
        table_q[idx].stall_on = stall_on;
        table_q[idx].strobe_busy = strobe;
    endtask

    task automatic load_table();
        set_entry(0, "single_beat",       6'd5,  32'h1000_0000, 32'hFFFF_FFFF, 1, 0, 0);
        set_entry(1, "three_beats",       6'd17, 32'h2000_1237, 32'h0000_00F0, 3, 0, 0);
        set_entry(2, "eight_beats",       6'd42, 32'hDEAD_BEFF, 32'hA5A5_5A5A, 8, 0, 0);
        set_entry(3, "eight_beats_stall", 6'd63, 32'h8000_001C, 32'h1234_5678, 8, 1, 0);
        set_entry(4, "three_beats_stall", 6'd0,  32'h0000_0FFC, 32'h0F0F_0F0F, 3, 1, 0);
        set_entry(5, "busy_strobe",       6'd9,  32'h4000_0040, 32'hFFFF_0000, 8, 0, 1);
        set_entry(6, "busy_strobe_stall", 6'd33, 32'h7FFF_FFE0, 32'h0000_FFFF, 3, 1, 1);
        set_entry(7, "back_to_back",      6'd1,  32'h0000_0020, 32'h0000_0001, 1, 0, 0);
    endtask

    // read data returns one cycle after sram_rd_en
    always @(negedge clk) begin
        if (rd_seen) begin
            sram_rddata <= model_row(rd_row_seen);
        end else begin
            sram_rddata <= '0;
        end
        rd_seen <= sram_rd_en;
        rd_row_seen <= sram_rd_row;
    end

    task automatic run_entry(input int idx);
        entry_t          e;
        string           name;
        wb_cmd_t         decoy;
        dram_write_req_t req;
        dram_write_req_t prev_req;
        logic            stall;
        logic            transfer;
        logic            prev_hold;
        logic            running;
        int              n;
        int              j;
        int              beats_seen;
        int              rd_count;
        int              done_count;

        e = table_q[idx];
        name = names[idx];
        n = int'(e.cmd.num_beats);
        decoy.row = e.cmd.row ^ 6'h3F;
        decoy.dram_addr = ~e.cmd.dram_addr;
        decoy.vector_mask = ~e.cmd.vector_mask;
        decoy.num_beats = beat_count_t'(2);
        prev_req = '0;
        prev_hold = 1'b0;
        beats_seen = 0;
        rd_count = 0;
        done_count = 0;
        j = 0;

        @(negedge clk);
        cmd_valid = 1'b1;
        cmd = e.cmd;
        draw_stall(e.stall_on, stall);
        dram_be_stall = stall;

        running = 1'b1;
        while (running) begin
            @(negedge clk);
            // a second command while busy must be dropped
            if (e.strobe_busy && busy && (j % 2 == 0)) begin
                cmd_valid = 1'b1;
                cmd = decoy;
            end else begin
                cmd_valid = 1'b0;
                cmd = '0;
            end
            draw_stall(e.stall_on, stall);
            dram_be_stall = stall;
            #1;
            req = dram_write_req;
            if (j == 0) begin
                check_value(name, "busy after command", check_t'(1), check_t'(busy));
            end
            if (sram_rd_en) begin
                rd_count++;
                check_value(name, "sram row", check_t'(e.cmd.row), check_t'(sram_rd_row));
            end
            if (prev_hold) begin
                check_value(name, "request under stall", check_t'(prev_req), check_t'(req));
            end
            transfer = req.valid && !stall;
            if (transfer) begin
                if (!e.stall_on) begin
                    check_value(name, "beat cycle", check_t'(4 + beats_seen), check_t'(j));
                end
                check_value(name, "wdata", check_t'(expect_wdata(e.cmd.row, beats_seen)),
                            check_t'(req.wdata));
                check_value(name, "address", check_t'(expect_addr(e.cmd.dram_addr, beats_seen)),
                            check_t'(req.dram_addr));
                check_value(name, "mask", check_t'(e.cmd.vector_mask),
                            check_t'(req.vector_mask));
                check_value(name, "done", check_t'(beats_seen == n - 1), check_t'(done));
                beats_seen++;
            end else begin
                check_value(name, "done without transfer", check_t'(0), check_t'(done));
            end
            if (done) begin
                done_count++;
            end
            prev_hold = req.valid && stall;
            prev_req = req;
            j++;
            running = busy;
        end

        check_value(name, "valid after busy drops", check_t'(0), check_t'(req.valid));
        check_value(name, "sram reads", check_t'(1), check_t'(rd_count));
        check_value(name, "beats transferred", check_t'(n), check_t'(beats_seen));
        check_value(name, "done pulses", check_t'(1), check_t'(done_count));
    endtask

    initial begin
        n_rst = 1'b0;
        cmd_valid = 1'b0;
        cmd = '0;
        dram_be_stall = 1'b0;
        lfsr_q = LFSR_SEED;
        load_table();
        repeat (RESET_CYCLES) @(negedge clk);
        n_rst = 1'b1;
        #1;
        check_value("reset", "busy", check_t'(0), check_t'(busy));
        check_value("reset", "done", check_t'(0), check_t'(done));
        check_value("reset", "sram_rd_en", check_t'(0), check_t'(sram_rd_en));
        check_value("reset", "request valid", check_t'(0), check_t'(dram_write_req.valid));
        for (int idx = 0; idx < NUM_ENTRIES; idx++) begin
            run_entry(idx);
        end
        $display("all tests passed");
        $finish;
    end

    // guards against a stuck sequencer
    initial begin
        repeat (RESET_CYCLES + ENTRY_CYCLES * NUM_ENTRIES) @(posedge clk);
        $display("timeout: the run did not finish in %0d cycles",
                 RESET_CYCLES + ENTRY_CYCLES * NUM_ENTRIES);
        $display("tests failed");
        $fatal(1, "run timed out");
    end

endmodule

//--- list.f
+incdir+logic
logic/scpad_pkg.sv
logic/wb_beat_counter.sv
logic/wb_row_buffer.sv
logic/wb_beat_packer.sv
logic/wb_ctrl_fsm.sv
logic/dram_writeback_top.sv
verif/dram_writeback_tb.sv

//--- run.sh
#!/bin/sh
# builds and runs the writeback testbench with verilator
# exit status is zero only when the simulation passes

cd "$(dirname "$0")"
status=$?
if [ $status -ne 0 ]; then
    echo "cannot enter project directory"
    exit $status
fi

verilator --binary --timing -Wno-fatal \
    -f list.f \
    --top-module dram_writeback_tb \
    --Mdir obj_dir \
    -o dram_writeback_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/dram_writeback_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
